// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := battle_scene_tb
FILELIST  := files.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := >>> PASS

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qxF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
source/battle_pkg.sv
source/sprite_addr_gen.sv
source/hp_bar.sv
source/move_cursor.sv
source/battle_layer_ctrl.sv
source/battle_scene_top.sv
tb/battle_scene_sva.sv
tb/battle_scene_tb.sv

// File: source/battle_layer_ctrl.sv
// layer controller, priority choice between overlays and the registered output pixel record
`timescale 1ns/1ns

module battle_layer_ctrl (
   input  logic                      Clk,
   input  logic                      rst_n,
   input  battle_pkg::sprite_hit_t   my_sprite,
   input  battle_pkg::sprite_hit_t   enemy_sprite,
   input  battle_pkg::hp_pix_t       my_bar,
   input  battle_pkg::hp_pix_t       enemy_bar,
   input  battle_pkg::glyph_hit_t    cursor,
   output battle_pkg::battle_pixel_t pixel_out
);
   import battle_pkg::*;

   layer_e        layer_sel;
   battle_pixel_t pixel_next;

   // cursor over bars over enemy over own sprite
   always_comb begin
      if (cursor.hit) begin
         layer_sel = LAYER_CURSOR;
      end else if (my_bar.hit || enemy_bar.hit) begin
         layer_sel = LAYER_HP;
      end else if (enemy_sprite.hit) begin
         layer_sel = LAYER_ENEMY;
      end else if (my_sprite.hit) begin
         layer_sel = LAYER_MY;
      end else begin
         layer_sel = LAYER_NONE;
      end
   end

   // only the winner's fields are carried, the rest stay zero
   always_comb begin
      pixel_next       = '0;
      pixel_next.layer = layer_sel;
      case (layer_sel)
         LAYER_CURSOR: begin
            pixel_next.char_code = cursor.char_code;
            pixel_next.glyph_col = cursor.glyph_col;
            pixel_next.glyph_row = cursor.glyph_row;
         end
         LAYER_HP: begin
            // own bar wins where both bars would hit
            pixel_next.color = my_bar.hit ? my_bar.color : enemy_bar.color;
         end
         LAYER_ENEMY: begin
            pixel_next.addr = enemy_sprite.addr;
         end
         LAYER_MY: begin
            pixel_next.addr = my_sprite.addr;
         end
         default: begin
            // background, the font draws a space
            pixel_next = BLANK_PIXEL;
         end
      endcase
   end

   // single pipeline stage
   // one cycle from scan position to pixel record
   always_ff @(posedge Clk or negedge rst_n) begin
      if (!rst_n) begin
         pixel_out <= BLANK_PIXEL;
      end else begin
         pixel_out <= pixel_next;
      end
   end

endmodule

// File: source/battle_pkg.sv
// battle screen package with screen layout, sprite sheet geometry, colours and pixel records
package battle_pkg;

   // scan position, column then row
   typedef struct packed {
      logic [9:0] draw_x;
      logic [9:0] draw_y;
   } pixel_pos_t;

   // sprite box and sheet geometry
   localparam logic [9:0] SPRITE_SIZE    = 10'd56;
   localparam logic [9:0] SHEET_WIDTH    = 10'd224;
   localparam logic [9:0] MY_SPRITE_X    = 10'd250;
   localparam logic [9:0] MY_SPRITE_Y    = 10'd290;
   localparam logic [9:0] ENEMY_SPRITE_X = 10'd410;
   localparam logic [9:0] ENEMY_SPRITE_Y = 10'd160;

   // back sheet column is 0, front sheet column is 1
   typedef enum logic {
      MY_SIDE    = 1'b0,
      ENEMY_SIDE = 1'b1
   } team_side_e;

   typedef logic [2:0]  poke_id_t;
   typedef logic [18:0] sheet_addr_t;

   typedef struct packed {
      logic        hit;
      sheet_addr_t addr;
   } sprite_hit_t;

   // hp bars
   typedef struct packed {
      logic [6:0] max_hp;
      logic [6:0] cur_hp;
   } hp_stat_t;

   localparam logic [9:0] HP_BAR_WIDTH  = 10'd50;
   localparam logic [9:0] HP_BAR_HEIGHT = 10'd5;
   // fill origin, the border ring sits one pixel outside
   localparam logic [9:0] MY_BAR_X      = 10'd430;
   localparam logic [9:0] MY_BAR_Y      = 10'd270;
   localparam logic [9:0] ENEMY_BAR_X   = 10'd110;
   localparam logic [9:0] ENEMY_BAR_Y   = 10'd80;

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   localparam rgb_t COLOR_BORDER = '{red: 8'h00, green: 8'h00, blue: 8'h00};
   localparam rgb_t COLOR_EMPTY  = '{red: 8'hff, green: 8'hff, blue: 8'hff};
   // above half
   localparam rgb_t COLOR_HIGH   = '{red: 8'h41, green: 8'hff, blue: 8'h74};
   // above a fifth
   localparam rgb_t COLOR_MID    = '{red: 8'h41, green: 8'hcc, blue: 8'h00};
   localparam rgb_t COLOR_LOW    = '{red: 8'hff, green: 8'h33, blue: 8'h00};

   typedef struct packed {
      logic hit;
      rgb_t color;
   } hp_pix_t;

   // move selection pointer
   typedef logic [1:0] move_idx_t;

   localparam logic [9:0] MOVE_ORIGIN_X = 10'd40;
   localparam logic [9:0] MOVE_ORIGIN_Y = 10'd400;
   localparam logic [9:0] MOVE_COL_STEP = 10'd150;
   localparam logic [9:0] MOVE_ROW_STEP = 10'd40;
   localparam logic [9:0] CURSOR_GAP    = 10'd9;
   localparam logic [9:0] GLYPH_W       = 10'd8;
   localparam logic [9:0] GLYPH_H       = 10'd16;
   localparam logic [7:0] CURSOR_CHAR   = 8'h3e;
   // space character, drawn when nothing owns the pixel
   localparam logic [7:0] BLANK_CHAR    = 8'h20;

   typedef struct packed {
      logic       hit;
      logic [7:0] char_code;
      logic [2:0] glyph_col;
      logic [9:0] glyph_row;
   } glyph_hit_t;

   // composited output record
   typedef enum logic [2:0] {
      LAYER_NONE   = 3'd0,
      LAYER_CURSOR = 3'd1,
      LAYER_HP     = 3'd2,
      LAYER_ENEMY  = 3'd3,
      LAYER_MY     = 3'd4
   } layer_e;

   typedef struct packed {
      layer_e      layer;
      sheet_addr_t addr;
      rgb_t        color;
      logic [7:0]  char_code;
      logic [2:0]  glyph_col;
      logic [9:0]  glyph_row;
   } battle_pixel_t;

   localparam battle_pixel_t BLANK_PIXEL = '{
      layer: LAYER_NONE, addr: '0, color: '0,
      char_code: BLANK_CHAR, glyph_col: '0, glyph_row: '0
   };

endpackage

// File: source/battle_scene_top.sv
// battle scene top level, two sprite generators, two hp bars, the move cursor and the layer controller
`timescale 1ns/1ns

module battle_scene_top (
   input  logic                      Clk,
   input  logic                      rst_n,
   input  battle_pkg::pixel_pos_t    draw_pos,
   input  battle_pkg::poke_id_t      my_id,
   input  battle_pkg::poke_id_t      enemy_id,
   input  battle_pkg::hp_stat_t      my_hp,
   input  battle_pkg::hp_stat_t      enemy_hp,
   input  battle_pkg::move_idx_t     hovered_move,
   output battle_pkg::battle_pixel_t pixel_out
);
   import battle_pkg::*;

   // per-overlay hit records for the current scan position
   sprite_hit_t my_sprite;
   sprite_hit_t enemy_sprite;
   hp_pix_t     my_bar;
   hp_pix_t     enemy_bar;
   glyph_hit_t  cursor;

   // back-facing own sprite
   sprite_addr_gen my_sprite_gen (
      .draw_pos (draw_pos),
      .side     (MY_SIDE),
      .poke_id  (my_id),
      .sprite   (my_sprite)
   );

   // front-facing enemy sprite
   sprite_addr_gen enemy_sprite_gen (
      .draw_pos (draw_pos),
      .side     (ENEMY_SIDE),
      .poke_id  (enemy_id),
      .sprite   (enemy_sprite)
   );

   hp_bar my_hp_bar (
      .draw_pos (draw_pos),
      .side     (MY_SIDE),
      .hp       (my_hp),
      .bar      (my_bar)
   );

   hp_bar enemy_hp_bar (
      .draw_pos (draw_pos),
      .side     (ENEMY_SIDE),
      .hp       (enemy_hp),
      .bar      (enemy_bar)
   );

   move_cursor cursor_gen (
      .draw_pos     (draw_pos),
      .hovered_move (hovered_move),
      .cursor       (cursor)
   );

   // priority pick and output register
   battle_layer_ctrl layer_ctrl (
      .Clk          (Clk),
      .rst_n        (rst_n),
      .my_sprite    (my_sprite),
      .enemy_sprite (enemy_sprite),
      .my_bar       (my_bar),
      .enemy_bar    (enemy_bar),
      .cursor       (cursor),
      .pixel_out    (pixel_out)
   );

endmodule

// File: source/hp_bar.sv
// hp bar, black border ring, fraction-coloured fill and white empty part for one team
`timescale 1ns/1ns

module hp_bar (
   input  battle_pkg::pixel_pos_t draw_pos,
   input  battle_pkg::team_side_e side,
   input  battle_pkg::hp_stat_t   hp,
   output battle_pkg::hp_pix_t    bar
);
   import battle_pkg::*;

   // fill origin for this side
   logic [9:0]  bar_x;
   logic [9:0]  bar_y;
   // position relative to the ring's top left corner
   logic [9:0]  ring_x;
   logic [9:0]  ring_y;
   // position relative to the fill origin
   logic [9:0]  fill_x;
   logic        in_outer;
   logic        on_ring;
   logic        in_fill;
   logic [12:0] scaled_hp;
   logic [12:0] fill_len;
   logic        over_half;
   logic        over_fifth;
   rgb_t        fill_color;

   assign bar_x = (side == ENEMY_SIDE) ? ENEMY_BAR_X : MY_BAR_X;
   assign bar_y = (side == ENEMY_SIDE) ? ENEMY_BAR_Y : MY_BAR_Y;

   // ring origin is one pixel up and left of the fill origin
   assign ring_x = draw_pos.draw_x - (bar_x - 10'd1);
   assign ring_y = draw_pos.draw_y - (bar_y - 10'd1);
   assign fill_x = ring_x - 10'd1;

   // bar plus one pixel on every side
   assign in_outer = (ring_x < HP_BAR_WIDTH + 10'd2) && (ring_y < HP_BAR_HEIGHT + 10'd2);

   // outermost row or column of that rectangle
   assign on_ring = in_outer &&
                    ((ring_x == 10'd0) || (ring_x == HP_BAR_WIDTH + 10'd1) ||
                     (ring_y == 10'd0) || (ring_y == HP_BAR_HEIGHT + 10'd1));

   // fill length in pixels, truncating division
   assign scaled_hp = 13'(HP_BAR_WIDTH) * 13'(hp.cur_hp);
   // zero max would divide by zero, show an empty bar
   assign fill_len  = (hp.max_hp == '0) ? '0 : scaled_hp / 13'(hp.max_hp);

   assign in_fill = 13'(fill_x) < fill_len;

   // thresholds on the fill length itself
   assign over_half  = 14'({fill_len, 1'b0}) > 14'(HP_BAR_WIDTH);
   assign over_fifth = 16'(fill_len) * 16'd5 > 16'(HP_BAR_WIDTH);

   always_comb begin
      if (over_half) begin
         fill_color = COLOR_HIGH;
      end else if (over_fifth) begin
         fill_color = COLOR_MID;
      end else begin
         fill_color = COLOR_LOW;
      end
   end

   // ring first, then fill, then the empty remainder
   always_comb begin
      bar.hit   = 1'b0;
      bar.color = '0;
      if (on_ring) begin
         bar.hit   = 1'b1;
         bar.color = COLOR_BORDER;
      end else if (in_outer) begin
         bar.hit   = 1'b1;
         bar.color = in_fill ? fill_color : COLOR_EMPTY;
      end
   end

endmodule

// File: source/move_cursor.sv
// move cursor, places the pointer glyph beside the hovered move and reports glyph coordinates
`timescale 1ns/1ns

module move_cursor (
   input  battle_pkg::pixel_pos_t draw_pos,
   input  battle_pkg::move_idx_t  hovered_move,
   output battle_pkg::glyph_hit_t cursor
);
   import battle_pkg::*;

   logic [9:0] ptr_x;
   logic [9:0] ptr_y;
   // local glyph coordinates
   logic [9:0] glyph_x;
   logic [9:0] glyph_y;
   logic       in_glyph;

   // moves laid out 2 by 2
   // bit 0 picks the column, bit 1 the row
   assign ptr_x = MOVE_ORIGIN_X + (hovered_move[0] ? MOVE_COL_STEP : 10'd0) - CURSOR_GAP;
   assign ptr_y = MOVE_ORIGIN_Y + (hovered_move[1] ? MOVE_ROW_STEP : 10'd0);

   // wraps high when left of or above the pointer
   assign glyph_x = draw_pos.draw_x - ptr_x;
   assign glyph_y = draw_pos.draw_y - ptr_y;

   assign in_glyph = (glyph_x < GLYPH_W) && (glyph_y < GLYPH_H);

   always_comb begin
      cursor.hit       = in_glyph;
      cursor.char_code = '0;
      cursor.glyph_col = '0;
      cursor.glyph_row = '0;
      if (in_glyph) begin
         // '>' pointer character
         cursor.char_code = CURSOR_CHAR;
         // glyph is 8 wide, low bits are the column
         cursor.glyph_col = glyph_x[2:0];
         cursor.glyph_row = glyph_y;
      end
   end

endmodule

// File: source/sprite_addr_gen.sv
// sprite address generator, box hit test and sheet address for one team's sprite
`timescale 1ns/1ns

module sprite_addr_gen (
   input  battle_pkg::pixel_pos_t  draw_pos,
   input  battle_pkg::team_side_e  side,
   input  battle_pkg::poke_id_t    poke_id,
   output battle_pkg::sprite_hit_t sprite
);
   import battle_pkg::*;

   // box origin for this side
   logic [9:0]  org_x;
   logic [9:0]  org_y;
   // position inside the box
   logic [9:0]  loc_x;
   logic [9:0]  loc_y;
   logic        in_box;
   // sheet tile coordinates
   logic [1:0]  sheet_col;
   logic [1:0]  sheet_row;
   sheet_addr_t line_base;
   sheet_addr_t page_base;
   sheet_addr_t col_base;

   assign org_x = (side == ENEMY_SIDE) ? ENEMY_SPRITE_X : MY_SPRITE_X;
   assign org_y = (side == ENEMY_SIDE) ? ENEMY_SPRITE_Y : MY_SPRITE_Y;

   // left of or above the origin wraps to a large value
   assign loc_x = draw_pos.draw_x - org_x;
   assign loc_y = draw_pos.draw_y - org_y;

   assign in_box = (loc_x < SPRITE_SIZE) && (loc_y < SPRITE_SIZE);

   // sheet is 4 tiles wide
   // even ids use columns 0/1, odd ids columns 2/3
   // back view left, front view right within each pair
   assign sheet_col = {poke_id[0], side};
   // two ids per tile row
   assign sheet_row = poke_id[2:1];

   // one sheet line per sprite row
   assign line_base = sheet_addr_t'(loc_y) * sheet_addr_t'(SHEET_WIDTH);

   // full tile row of the sheet per id pair
   assign page_base = sheet_addr_t'(sheet_row) * sheet_addr_t'(SHEET_WIDTH)
                    * sheet_addr_t'(SPRITE_SIZE);

   assign col_base = sheet_addr_t'(sheet_col) * sheet_addr_t'(SPRITE_SIZE);

   always_comb begin
      sprite.hit  = in_box;
      // address held at zero off the box
      sprite.addr = '0;
      if (in_box) begin
         sprite.addr = sheet_addr_t'(loc_x) + line_base + page_base + col_base;
      end
   end

endmodule

// File: tb/battle_scene_sva.sv
// layer controller assertions, blank record in reset, blank background fields, cursor priority
`timescale 1ns/1ns

module battle_scene_sva (
   input logic                      Clk,
   input logic                      rst_n,
   input battle_pkg::glyph_hit_t    cursor,
   input battle_pkg::battle_pixel_t pixel_out
);
   import battle_pkg::*;

   // register loads the blank record on every edge seen in reset
   property blank_in_reset;
      @(posedge Clk) !rst_n |=> (pixel_out == BLANK_PIXEL);
   endproperty

   // background always draws a space with no sheet address
   property blank_fields;
      @(posedge Clk) disable iff (!rst_n)
         (pixel_out.layer == LAYER_NONE) |-> (pixel_out.char_code == BLANK_CHAR &&
                                              pixel_out.addr == '0);
   endproperty

   // cursor is top priority, one register stage later
   property cursor_wins;
      @(posedge Clk) disable iff (!rst_n) cursor.hit |=> (pixel_out.layer == LAYER_CURSOR);
   endproperty

   a_blank_in_reset: assert property (blank_in_reset)
      else $error("pixel_out is not the blank record while reset is low");
   a_blank_fields: assert property (blank_fields)
      else $error("background pixel carries a wrong character or a sheet address");
   a_cursor_wins: assert property (cursor_wins)
      else $error("cursor hit did not give the cursor layer one cycle later");

endmodule

bind battle_layer_ctrl battle_scene_sva layer_sva (
   .Clk       (Clk),
   .rst_n     (rst_n),
   .cursor    (cursor),
   .pixel_out (pixel_out)
);

// File: tb/battle_scene_tb.sv
// battle scene testbench driving LFSR stimulus against a reference model with one cycle of latency
`timescale 1ns/1ns

module battle_scene_tb;
   import battle_pkg::*;

   logic          Clk;
   logic          rst_n;
   pixel_pos_t    draw_pos;
   poke_id_t      my_id;
   poke_id_t      enemy_id;
   hp_stat_t      my_hp;
   hp_stat_t      enemy_hp;
   move_idx_t     hovered_move;
   battle_pixel_t pixel_out;

   // scene state applied together with the next position
   poke_id_t      s_my_id;
   poke_id_t      s_enemy_id;
   hp_stat_t      s_my_hp;
   hp_stat_t      s_enemy_hp;
   move_idx_t     s_move;

   logic [31:0]   lfsr_state;
   battle_pixel_t expect_q[$];
   // record popped and waiting for its compare
   logic          in_flight;
   int            checks;
   int            errors;
   int            timeouts;
   // max 100 around the half and fifth thresholds and then a zero max
   int            hp_max[14] = '{100, 100, 100, 100, 100, 100, 100, 100, 100, 100, 100, 100, 0, 0};
   int            hp_cur[14] = '{100, 53, 52, 51, 50, 23, 22, 21, 20, 2, 1, 0, 0, 9};
   // random positions aimed near each overlay
   int            anchor_x[6] = '{246, 406, 426, 106, 27, 177};
   int            anchor_y[6] = '{286, 156, 266, 76, 396, 436};

   battle_scene_top battle_scene_top_inst (
      .Clk          (Clk),
      .rst_n        (rst_n),
      .draw_pos     (draw_pos),
      .my_id        (my_id),
      .enemy_id     (enemy_id),
      .my_hp        (my_hp),
      .enemy_hp     (enemy_hp),
      .hovered_move (hovered_move),
      .pixel_out    (pixel_out)
   );

   always #5 Clk = ~Clk;

   // galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h80200003;
      end
      return state >> 1;
   endfunction

   function automatic int take_bits(input int n);
      int val;
      val = 0;
      for (int i = 0; i < n; i++) begin
         val = (val << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
      return val;
   endfunction

   function automatic battle_pixel_t blank_ref();
      battle_pixel_t res;
      res = '0;
      res.layer = LAYER_NONE;
      res.char_code = 8'h20;
      return res;
   endfunction

   function automatic int fill_ref(input hp_stat_t hp);
      if (int'(hp.max_hp) == 0) begin
         return 0;
      end
      return 50 * int'(hp.cur_hp) / int'(hp.max_hp);
   endfunction

   // sheet address or -1 off the 56 pixel box
   function automatic int sprite_ref(input int x, input int y, input int side, input int id);
      int ox;
      int oy;
      ox = (side == 1) ? 410 : 250;
      oy = (side == 1) ? 160 : 290;
      if (x < ox || x >= ox + 56 || y < oy || y >= oy + 56) begin
         return -1;
      end
      return (x - ox) + 224 * (y - oy) + 224 * 56 * (id / 2) + 56 * ((id % 2) * 2 + side);
   endfunction

   function automatic logic bar_ref(input int x, input int y, input int side,
                                    input hp_stat_t hp, output rgb_t c);
      int bx;
      int by;
      int len;
      bx = (side == 1) ? 110 : 430;
      by = (side == 1) ? 80 : 270;
      len = fill_ref(hp);
      c = '0;
      if (x < bx - 1 || x > bx + 50 || y < by - 1 || y > by + 5) begin
         return 1'b0;
      end
      if (x == bx - 1 || x == bx + 50 || y == by - 1 || y == by + 5) begin
         c = '{8'h00, 8'h00, 8'h00};
      end else if (x - bx >= len) begin
         c = '{8'hff, 8'hff, 8'hff};
      end else if (2 * len > 50) begin
         c = '{8'h41, 8'hff, 8'h74};
      end else if (5 * len > 50) begin
         c = '{8'h41, 8'hcc, 8'h00};
      end else begin
         c = '{8'hff, 8'h33, 8'h00};
      end
      return 1'b1;
   endfunction

   function automatic battle_pixel_t ref_pixel(input pixel_pos_t p, input poke_id_t mid,
         input poke_id_t eid, input hp_stat_t mhp, input hp_stat_t ehp, input move_idx_t mv);
      int            x;
      int            y;
      int            px;
      int            py;
      int            my_a;
      int            en_a;
      logic          my_bar_hit;
      logic          en_bar_hit;
      rgb_t          my_c;
      rgb_t          en_c;
      battle_pixel_t res;
      x = int'(p.draw_x);
      y = int'(p.draw_y);
      // pointer sits 9 pixels left of the move text
      px = 40 + 150 * int'(mv[0]) - 9;
      py = 400 + 40 * int'(mv[1]);
      my_a = sprite_ref(x, y, 0, int'(mid));
      en_a = sprite_ref(x, y, 1, int'(eid));
      my_bar_hit = bar_ref(x, y, 0, mhp, my_c);
      en_bar_hit = bar_ref(x, y, 1, ehp, en_c);
      res = '0;
      if (x >= px && x < px + 8 && y >= py && y < py + 16) begin
         res.layer = LAYER_CURSOR;
         res.char_code = 8'h3e;
         res.glyph_col = 3'(x - px);
         res.glyph_row = 10'(y - py);
      end else if (my_bar_hit) begin
         res.layer = LAYER_HP;
         res.color = my_c;
      end else if (en_bar_hit) begin
         res.layer = LAYER_HP;
         res.color = en_c;
      end else if (en_a >= 0) begin
         res.layer = LAYER_ENEMY;
         res.addr = sheet_addr_t'(en_a);
      end else if (my_a >= 0) begin
         res.layer = LAYER_MY;
         res.addr = sheet_addr_t'(my_a);
      end else begin
         res = blank_ref();
      end
      return res;
   endfunction

   task automatic check_layer(input string name, input layer_e got, input layer_e exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %s expected %s", $time, name, got.name(),
                  exp.name());
      end
   endtask

   task automatic check_addr(input string name, input sheet_addr_t got, input sheet_addr_t exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_color(input string name, input rgb_t got, input rgb_t exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_glyph(input string name, input glyph_hit_t got, input glyph_hit_t exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_pixel(input battle_pixel_t exp_pix);
      glyph_hit_t got_g;
      glyph_hit_t exp_g;
      got_g = '{pixel_out.layer == LAYER_CURSOR, pixel_out.char_code, pixel_out.glyph_col,
                pixel_out.glyph_row};
      exp_g = '{exp_pix.layer == LAYER_CURSOR, exp_pix.char_code, exp_pix.glyph_col,
                exp_pix.glyph_row};
      check_layer("pixel_out.layer", pixel_out.layer, exp_pix.layer);
      check_addr("pixel_out.addr", pixel_out.addr, exp_pix.addr);
      check_color("pixel_out.color", pixel_out.color, exp_pix.color);
      check_glyph("pixel_out glyph", got_g, exp_g);
   endtask

   task automatic drive_pos(input int x, input int y);
      pixel_pos_t p;
      @(negedge Clk);
      p.draw_x = 10'(x);
      p.draw_y = 10'(y);
      draw_pos = p;
      my_id = s_my_id;
      enemy_id = s_enemy_id;
      my_hp = s_my_hp;
      enemy_hp = s_enemy_hp;
      hovered_move = s_move;
      expect_q.push_back(ref_pixel(p, s_my_id, s_enemy_id, s_my_hp, s_enemy_hp, s_move));
   endtask

   task automatic wait_drain(input string phase);
      int cycles;
      cycles = 0;
      while ((expect_q.size() != 0 || in_flight) && cycles < 8) begin
         @(posedge Clk);
         #2;
         cycles++;
      end
      if (expect_q.size() != 0 || in_flight) begin
         timeouts++;
         $display("timeout: %s results still pending after %0d cycles", phase, cycles);
         expect_q.delete();
      end
   endtask

   // record is loaded on the rising edge after its position
   // and must still hold once the next position is on the inputs
   initial begin
      battle_pixel_t exp_pix;
      forever begin
         @(posedge Clk);
         #1;
         if (expect_q.size() != 0) begin
            exp_pix = expect_q.pop_front();
            in_flight = 1'b1;
            @(negedge Clk);
            #1;
            compare_pixel(exp_pix);
            in_flight = 1'b0;
         end
      end
   end

   initial begin
      int ox;
      int oy;
      int bx;
      int by;
      int len;
      int mx;
      int sel;
      Clk = 1'b0;
      rst_n = 1'b0;
      draw_pos = '0;
      my_id = '0;
      enemy_id = '0;
      my_hp = '0;
      enemy_hp = '0;
      hovered_move = '0;
      s_my_id = '0;
      s_enemy_id = '0;
      s_my_hp = '{7'd100, 7'd100};
      s_enemy_hp = '{7'd100, 7'd100};
      s_move = '0;
      lfsr_state = 32'ha454e82a;
      in_flight = 1'b0;
      checks = 0;
      errors = 0;
      timeouts = 0;
      repeat (3) @(posedge Clk);
      @(negedge Clk);
      rst_n = 1'b1;
      // nothing applied yet
      compare_pixel(blank_ref());

      // sprite box corners, points just outside and random interior points
      for (int id = 0; id < 8; id++) begin
         s_my_id = 3'(id);
         s_enemy_id = 3'(7 - id);
         for (int side = 0; side < 2; side++) begin
            ox = (side == 1) ? 410 : 250;
            oy = (side == 1) ? 160 : 290;
            drive_pos(ox, oy);
            drive_pos(ox + 55, oy);
            drive_pos(ox, oy + 55);
            drive_pos(ox + 55, oy + 55);
            drive_pos(ox - 1, oy);
            drive_pos(ox + 56, oy + 55);
            drive_pos(ox, oy + 56);
            for (int k = 0; k < 6; k++) begin
               drive_pos(ox + take_bits(6) % 56, oy + take_bits(6) % 56);
            end
         end
      end
      wait_drain("sprite scan");

      // hp bar ring, fill edge, empty part and outside points
      for (int i = 0; i < 14; i++) begin
         s_my_hp.max_hp = 7'(hp_max[i]);
         s_my_hp.cur_hp = 7'(hp_cur[i]);
         s_enemy_hp.max_hp = 7'(hp_max[13 - i]);
         s_enemy_hp.cur_hp = 7'(hp_cur[13 - i]);
         for (int side = 0; side < 2; side++) begin
            bx = (side == 1) ? 110 : 430;
            by = (side == 1) ? 80 : 270;
            len = fill_ref((side == 1) ? s_enemy_hp : s_my_hp);
            drive_pos(bx - 1, by - 1);
            drive_pos(bx + 50, by + 5);
            drive_pos(bx + 20, by - 1);
            drive_pos(bx - 1, by + 2);
            drive_pos(bx, by + 2);
            drive_pos(bx + len - 1, by + 1);
            drive_pos(bx + len, by + 3);
            drive_pos(bx + 49, by + 4);
            drive_pos(bx - 2, by);
            drive_pos(bx, by + 6);
         end
      end
      wait_drain("hp sweep");

      // glyph box plus a one pixel margin for each move
      for (int mv = 0; mv < 4; mv++) begin
         s_move = 2'(mv);
         ox = 31 + 150 * (mv % 2);
         oy = 400 + 40 * (mv / 2);
         for (int dy = -1; dy <= 16; dy++) begin
            for (int dx = -1; dx <= 8; dx++) begin
               drive_pos(ox + dx, oy + dy);
            end
         end
      end
      wait_drain("cursor scan");

      // random scene and position every cycle
      for (int n = 0; n < 3000; n++) begin
         s_my_id = 3'(take_bits(3));
         s_enemy_id = 3'(take_bits(3));
         mx = take_bits(7);
         s_my_hp.max_hp = 7'(mx);
         s_my_hp.cur_hp = 7'(take_bits(7) % (mx + 1));
         mx = take_bits(7);
         s_enemy_hp.max_hp = 7'(mx);
         s_enemy_hp.cur_hp = 7'(take_bits(7) % (mx + 1));
         s_move = 2'(take_bits(2));
         sel = take_bits(3);
         if (sel < 6) begin
            drive_pos(anchor_x[sel] + take_bits(6), anchor_y[sel] + take_bits(6));
         end else begin
            drive_pos(take_bits(10), take_bits(10));
         end
      end
      wait_drain("random traffic");

      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
